// File: verilog/npc_params.svh
`ifndef NPC_PARAMS_SVH
`define NPC_PARAMS_SVH

// word address of a fetch
`define NPC_ADDR_W 30

// table sizes
`define NPC_BTB_IDX_W 6
`define NPC_CPHT_IDX_W 6
`define NPC_RAS_DEPTH 16
`define NPC_RAS_PTR_W 4

// branch kind codes shared by decoder and execute
`define NPC_KIND_NOT_JUMP      3'd0
`define NPC_KIND_DIRECT_JUMP   3'd1
`define NPC_KIND_RET           3'd4
`define NPC_KIND_INDIRECT_JUMP 3'd5
`define NPC_KIND_CALL          3'd6
`define NPC_KIND_JUMP          3'd7

// weakly prefer the stack
`define NPC_CTR_INIT 2'd2

`endif

// File: verilog/npc_pkg.sv
`include "npc_params.svh"

package npc_pkg;

    // fetch or target word address
    typedef logic [`NPC_ADDR_W-1:0] addr_t;

    // branch kind, see NPC_KIND_* codes
    typedef logic [2:0] br_kind_t;

    // table indices, taken from the low address bits
    typedef logic [`NPC_BTB_IDX_W-1:0] btb_idx_t;
    typedef logic [`NPC_CPHT_IDX_W-1:0] cpht_idx_t;

    // return stack pointer, wraps at NPC_RAS_DEPTH
    typedef logic [`NPC_RAS_PTR_W-1:0] ras_ptr_t;

    // 2-bit saturating choice counter
    typedef logic [1:0] ctr_t;

endpackage

// File: verilog/btb.sv
`timescale 1ns/1ps

`include "npc_params.svh"

module btb
    import npc_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  addr_t    pc_reg,
    output logic     btb_hit,
    output addr_t    btb_target,
    input  logic     update_en,
    input  br_kind_t kind_ex,
    input  addr_t    pc_ex,
    input  addr_t    npc_ex
);

    localparam int ENTRIES = 1 << `NPC_BTB_IDX_W;

    addr_t target_mem [ENTRIES];
    logic [ENTRIES-1:0] valid;

    btb_idx_t rd_idx;
    btb_idx_t wr_idx;
    logic     wr_en;

    // tagless, so the low bits alone pick the entry
    assign rd_idx = pc_reg[`NPC_BTB_IDX_W-1:0];
    assign wr_idx = pc_ex[`NPC_BTB_IDX_W-1:0];

    // every resolved jump kind trains the buffer
    assign wr_en = update_en && (kind_ex != `NPC_KIND_NOT_JUMP);

    // target payload
    always_ff @(posedge clk) begin
        if (wr_en) begin
            target_mem[wr_idx] <= npc_ex;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid <= '0;
        end else if (wr_en) begin
            valid[wr_idx] <= 1'b1;
        end
    end

    // asynchronous read for same-cycle prediction
    assign btb_hit    = valid[rd_idx];
    assign btb_target = target_mem[rd_idx];

endmodule

// File: verilog/ras.sv
`timescale 1ns/1ps

`include "npc_params.svh"

module ras
    import npc_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     update_en,
    input  br_kind_t kind_ex,
    input  addr_t    ret_pc_ex,
    output logic     ras_valid,
    output addr_t    ras_target
);

    addr_t stack_mem [`NPC_RAS_DEPTH];

    // next free slot; top entry sits one below
    ras_ptr_t ptr;
    ras_ptr_t top_ptr;

    // occupancy needs one more bit than the pointer
    logic [`NPC_RAS_PTR_W:0] count;

    logic push;
    logic pop;
    logic full;
    logic empty;

    assign push  = update_en && (kind_ex == `NPC_KIND_CALL);
    assign pop   = update_en && (kind_ex == `NPC_KIND_RET);

    assign full  = (count == (`NPC_RAS_PTR_W + 1)'(`NPC_RAS_DEPTH));
    assign empty = (count == '0);

    assign top_ptr = ptr - ras_ptr_t'(1);

    // overwrite at the pointer even when full, oldest entry is lost
    always_ff @(posedge clk) begin
        if (push) begin
            stack_mem[ptr] <= ret_pc_ex;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ptr   <= '0;
            count <= '0;
        end else if (push) begin
            ptr <= ptr + ras_ptr_t'(1);
            if (!full) begin
                count <= count + 1'b1;
            end
        end else if (pop && !empty) begin
            ptr   <= top_ptr;
            count <= count - 1'b1;
        end
    end

    assign ras_valid  = !empty;
    assign ras_target = stack_mem[top_ptr];

endmodule

// File: verilog/target_chooser.sv
`timescale 1ns/1ps

`include "npc_params.svh"

module target_chooser
    import npc_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     stall,
    input  addr_t    pc_reg,
    input  br_kind_t kind_pdc,
    input  logic     taken_pdc,
    input  logic     btb_hit,
    input  addr_t    btb_target,
    input  logic     ras_valid,
    input  addr_t    ras_target,
    input  logic     update_en,
    input  br_kind_t kind_ex,
    input  addr_t    pc_ex,
    input  logic     choice_real,
    output addr_t    npc_pdc,
    output logic     choice_ras
);

    localparam int ENTRIES = 1 << `NPC_CPHT_IDX_W;

    ctr_t ctr [ENTRIES];

    cpht_idx_t rd_idx;
    cpht_idx_t wr_idx;
    logic      train;
    ctr_t      cur_ctr;

    addr_t fall_thru;
    addr_t btb_or_seq;

    assign rd_idx = pc_reg[`NPC_CPHT_IDX_W-1:0];
    assign wr_idx = pc_ex[`NPC_CPHT_IDX_W-1:0];

    // only resolved returns say anything about stack vs buffer
    assign train   = update_en && (kind_ex == `NPC_KIND_RET);
    assign cur_ctr = ctr[wr_idx];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < ENTRIES; i++) begin
                ctr[i] <= `NPC_CTR_INIT;
            end
        end else if (train) begin
            // saturating at 0 and 3
            if (choice_real) begin
                if (cur_ctr != 2'd3) begin
                    ctr[wr_idx] <= cur_ctr + 2'd1;
                end
            end else begin
                if (cur_ctr != 2'd0) begin
                    ctr[wr_idx] <= cur_ctr - 2'd1;
                end
            end
        end
    end

    // upper bit set means trust the stack
    assign choice_ras = ctr[rd_idx][1];

    // fetch pairs are aligned, so step to the next even word
    assign fall_thru = pc_reg[0] ? pc_reg + addr_t'(1) : pc_reg + addr_t'(2);

    // buffer miss falls through
    assign btb_or_seq = btb_hit ? btb_target : fall_thru;

    always_comb begin
        if (stall) begin
            npc_pdc = pc_reg;
        end else if (!taken_pdc) begin
            npc_pdc = fall_thru;
        end else begin
            case (kind_pdc)
                `NPC_KIND_RET: begin
                    if (choice_ras && ras_valid) begin
                        npc_pdc = ras_target;
                    end else begin
                        npc_pdc = btb_or_seq;
                    end
                end
                `NPC_KIND_DIRECT_JUMP,
                `NPC_KIND_INDIRECT_JUMP,
                `NPC_KIND_CALL,
                `NPC_KIND_JUMP: begin
                    npc_pdc = btb_or_seq;
                end
                // not a jump, or a code the decoder never emits
                default: begin
                    npc_pdc = fall_thru;
                end
            endcase
        end
    end

endmodule

// File: verilog/npc_predictor.sv
`timescale 1ns/1ps

module npc_predictor
    import npc_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     stall,
    input  logic     update_en,
    // predict side
    input  addr_t    pc_reg,
    input  br_kind_t kind_pdc,
    input  logic     taken_pdc,
    // execute side
    input  addr_t    pc_ex,
    input  addr_t    npc_ex,
    input  br_kind_t kind_ex,
    input  addr_t    ret_pc_ex,
    input  logic     choice_real,
    output addr_t    npc_pdc,
    output logic     choice_ras
);

    logic  btb_hit;
    addr_t btb_target;
    logic  ras_valid;
    addr_t ras_target;

    btb btb_i (
        .clk        (clk),
        .rstn       (rstn),
        .pc_reg     (pc_reg),
        .btb_hit    (btb_hit),
        .btb_target (btb_target),
        .update_en  (update_en),
        .kind_ex    (kind_ex),
        .pc_ex      (pc_ex),
        .npc_ex     (npc_ex)
    );

    ras ras_i (
        .clk        (clk),
        .rstn       (rstn),
        .update_en  (update_en),
        .kind_ex    (kind_ex),
        .ret_pc_ex  (ret_pc_ex),
        .ras_valid  (ras_valid),
        .ras_target (ras_target)
    );

    // merges both table results into the next fetch address
    target_chooser chooser_i (
        .clk         (clk),
        .rstn        (rstn),
        .stall       (stall),
        .pc_reg      (pc_reg),
        .kind_pdc    (kind_pdc),
        .taken_pdc   (taken_pdc),
        .btb_hit     (btb_hit),
        .btb_target  (btb_target),
        .ras_valid   (ras_valid),
        .ras_target  (ras_target),
        .update_en   (update_en),
        .kind_ex     (kind_ex),
        .pc_ex       (pc_ex),
        .choice_real (choice_real),
        .npc_pdc     (npc_pdc),
        .choice_ras  (choice_ras)
    );

endmodule

// File: bench/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
    parameter real PERIOD = 100.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // free running, first rising edge at half a period
    always begin
        #(PERIOD / 2.0) clk = ~clk;
    end

endmodule

// File: bench/npc_predictor_props.sv
`timescale 1ns/1ps

module npc_predictor_props
    import npc_pkg::*;
(
    input logic  clk,
    input logic  rstn,
    input logic  stall,
    input logic  taken_pdc,
    input addr_t pc_reg,
    input addr_t npc_pdc,
    input logic  choice_ras
);

    int hold_fails = 0;
    int seq_fails = 0;
    int even_fails = 0;
    int known_fails = 0;

    addr_t seq_pc;

    // next aligned fetch pair
    assign seq_pc = (pc_reg | addr_t'(1)) + addr_t'(1);

    stall_holds_pc: assert property (@(posedge clk) disable iff (!rstn)
        stall |-> npc_pdc == pc_reg)
    else begin
        hold_fails++;
        $error("npc_pdc moved away from pc_reg while stall was high");
    end

    not_taken_falls_through: assert property (@(posedge clk) disable iff (!rstn)
        (!stall && !taken_pdc) |-> npc_pdc == seq_pc)
    else begin
        seq_fails++;
        $error("npc_pdc is not the fall-through address for a not-taken fetch");
    end

    // a fall-through always lands on the start of a pair
    fall_through_even: assert property (@(posedge clk) disable iff (!rstn)
        (!stall && !taken_pdc) |-> !npc_pdc[0])
    else begin
        even_fails++;
        $error("fall-through address is odd");
    end

    choice_known: assert property (@(posedge clk) disable iff (!rstn)
        !$isunknown(choice_ras))
    else begin
        known_fails++;
        $error("choice_ras is unknown after reset");
    end

endmodule

// File: bench/npc_predictor_tb.sv
`timescale 1ns/1ps

`include "npc_params.svh"

module npc_predictor_tb
    import npc_pkg::*;
();

    localparam int BTB_N  = 1 << `NPC_BTB_IDX_W;
    localparam int CPHT_N = 1 << `NPC_CPHT_IDX_W;
    // reset plus all phases stay below about 1950 cycles
    localparam int MAX_CYCLES = 2100;

    logic     clk;
    logic     rstn;
    logic     stall;
    logic     update_en;
    addr_t    pc_reg;
    br_kind_t kind_pdc;
    logic     taken_pdc;
    addr_t    pc_ex;
    addr_t    npc_ex;
    br_kind_t kind_ex;
    addr_t    ret_pc_ex;
    logic     choice_real;
    addr_t    npc_pdc;
    logic     choice_ras;

    // shadow copies of the tables
    addr_t    btb_tgt [BTB_N];
    bit       btb_vld [BTB_N];
    addr_t    ras_mem [`NPC_RAS_DEPTH];
    ras_ptr_t ras_ptr;
    int       ras_cnt;
    ctr_t     ctr_m [CPHT_N];

    // small address pool so entries get hit again
    addr_t pool [32];

    int err_cnt = 0;
    int prop_errs = 0;
    int cycle_cnt = 0;
    int n;

    clk_gen clk_gen_i (
        .clk (clk)
    );

    npc_predictor dut_i (
        .clk         (clk),
        .rstn        (rstn),
        .stall       (stall),
        .update_en   (update_en),
        .pc_reg      (pc_reg),
        .kind_pdc    (kind_pdc),
        .taken_pdc   (taken_pdc),
        .pc_ex       (pc_ex),
        .npc_ex      (npc_ex),
        .kind_ex     (kind_ex),
        .ret_pc_ex   (ret_pc_ex),
        .choice_real (choice_real),
        .npc_pdc     (npc_pdc),
        .choice_ras  (choice_ras)
    );

    bind npc_predictor npc_predictor_props props_i (
        .clk        (clk),
        .rstn       (rstn),
        .stall      (stall),
        .taken_pdc  (taken_pdc),
        .pc_reg     (pc_reg),
        .npc_pdc    (npc_pdc),
        .choice_ras (choice_ras)
    );

    // start of the next aligned pair
    function automatic addr_t seq_next(input addr_t pc);
        return (pc & ~addr_t'(1)) + addr_t'(2);
    endfunction

    function automatic addr_t buffer_target(input addr_t pc);
        btb_idx_t idx;
        idx = pc[`NPC_BTB_IDX_W-1:0];
        if (btb_vld[idx]) begin
            return btb_tgt[idx];
        end
        return seq_next(pc);
    endfunction

    function automatic logic expected_choice();
        return ctr_m[pc_reg[`NPC_CPHT_IDX_W-1:0]][1];
    endfunction

    function automatic addr_t expected_npc();
        if (stall) begin
            return pc_reg;
        end
        if (!taken_pdc) begin
            return seq_next(pc_reg);
        end
        case (kind_pdc)
            `NPC_KIND_RET: begin
                if (expected_choice() && ras_cnt > 0) begin
                    return ras_mem[ras_ptr - ras_ptr_t'(1)];
                end
                return buffer_target(pc_reg);
            end
            `NPC_KIND_DIRECT_JUMP, `NPC_KIND_INDIRECT_JUMP, `NPC_KIND_CALL, `NPC_KIND_JUMP: begin
                return buffer_target(pc_reg);
            end
            default: begin
                return seq_next(pc_reg);
            end
        endcase
    endfunction

    function automatic br_kind_t jump_kind();
        logic [1:0] sel;
        sel = 2'($urandom);
        case (sel)
            2'd0: return `NPC_KIND_DIRECT_JUMP;
            2'd1: return `NPC_KIND_INDIRECT_JUMP;
            2'd2: return `NPC_KIND_CALL;
            default: return `NPC_KIND_JUMP;
        endcase
    endfunction

    function automatic br_kind_t ret_or_call();
        return (($urandom % 2) == 0) ? `NPC_KIND_RET : `NPC_KIND_CALL;
    endfunction

    // model side of an execute update at the clock edge
    task automatic apply_update();
        btb_idx_t  bi;
        cpht_idx_t ci;
        bi = pc_ex[`NPC_BTB_IDX_W-1:0];
        ci = pc_ex[`NPC_CPHT_IDX_W-1:0];
        if (update_en) begin
            if (kind_ex != `NPC_KIND_NOT_JUMP) begin
                btb_tgt[bi] = npc_ex;
                btb_vld[bi] = 1'b1;
            end
            if (kind_ex == `NPC_KIND_CALL) begin
                ras_mem[ras_ptr] = ret_pc_ex;
                ras_ptr = ras_ptr + ras_ptr_t'(1);
                if (ras_cnt < `NPC_RAS_DEPTH) begin
                    ras_cnt++;
                end
            end
            if (kind_ex == `NPC_KIND_RET) begin
                if (ras_cnt > 0) begin
                    ras_ptr = ras_ptr - ras_ptr_t'(1);
                    ras_cnt--;
                end
                if (choice_real && ctr_m[ci] != 2'd3) begin
                    ctr_m[ci] = ctr_m[ci] + 2'd1;
                end else if (!choice_real && ctr_m[ci] != 2'd0) begin
                    ctr_m[ci] = ctr_m[ci] - 2'd1;
                end
            end
        end
    endtask

    task automatic check_outputs();
        addr_t exp_npc;
        logic  exp_choice;
        exp_npc    = expected_npc();
        exp_choice = expected_choice();
        assert (npc_pdc == exp_npc && choice_ras == exp_choice) else begin
            err_cnt++;
            $display(
                "** Error at %0t: pc %h kind %0d npc exp %h got %h, choice_ras exp %b got %b",
                $time, pc_reg, kind_pdc, exp_npc, npc_pdc, exp_choice, choice_ras);
        end
    endtask

    // model update, new inputs and a mid-cycle check per clock
    task automatic drive_cycle(input logic upd, input br_kind_t kex, input br_kind_t kpd,
                               input logic tk, input logic creal);
        @(posedge clk);
        apply_update();
        stall       <= ($urandom % 6) == 0;
        pc_reg      <= pool[5'($urandom)];
        kind_pdc    <= kpd;
        taken_pdc   <= tk;
        update_en   <= upd;
        kind_ex     <= kex;
        pc_ex       <= pool[{1'b0, 4'($urandom)}];
        npc_ex      <= addr_t'($urandom);
        ret_pc_ex   <= addr_t'($urandom);
        choice_real <= creal;
        @(negedge clk);
        check_outputs();
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            $display("timeout: the test did not finish within %0d cycles", MAX_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h3f53_454b));
        rstn        = 1'b0;
        stall       = 1'b0;
        update_en   = 1'b0;
        pc_reg      = '0;
        kind_pdc    = `NPC_KIND_NOT_JUMP;
        taken_pdc   = 1'b0;
        pc_ex       = '0;
        npc_ex      = '0;
        kind_ex     = `NPC_KIND_NOT_JUMP;
        ret_pc_ex   = '0;
        choice_real = 1'b0;
        for (int i = 0; i < 32; i++) begin
            pool[i[4:0]] = addr_t'($urandom);
        end
        btb_vld = '{default: 1'b0};
        ctr_m   = '{default: `NPC_CTR_INIT};
        ras_ptr = '0;
        ras_cnt = 0;

        repeat (3) @(posedge clk);
        rstn <= 1'b1;

        // every taken kind falls through on empty tables
        repeat (200) begin
            drive_cycle(1'b0, `NPC_KIND_NOT_JUMP, br_kind_t'($urandom),
                        ($urandom % 4) != 0, 1'b0);
        end

        // target buffer training from half the pool
        repeat (450) begin
            drive_cycle(($urandom % 2) == 0, jump_kind(), jump_kind(),
                        ($urandom % 4) != 0, 1'b0);
        end

        // call chains up to 21 deep and unwinding past empty
        for (int b = 0; b < 14; b++) begin
            n = 12 + int'($urandom % 10);
            repeat (n) begin
                drive_cycle(1'b1, `NPC_KIND_CALL, `NPC_KIND_RET, 1'b1, 1'b1);
            end
            repeat (n + 3) begin
                drive_cycle(1'b1, `NPC_KIND_RET, `NPC_KIND_RET, 1'b1, 1'b1);
            end
        end

        // choice counter training
        repeat (450) begin
            drive_cycle(($urandom % 4) != 0, ret_or_call(), `NPC_KIND_RET,
                        ($urandom % 8) != 0, ($urandom % 2) == 0);
        end

        // fully random traffic with unknown kind codes
        repeat (200) begin
            drive_cycle(($urandom % 2) == 0, br_kind_t'($urandom), br_kind_t'($urandom),
                        ($urandom % 2) == 0, ($urandom % 2) == 0);
        end

        prop_errs = dut_i.props_i.hold_fails + dut_i.props_i.seq_fails
                  + dut_i.props_i.even_fails + dut_i.props_i.known_fails;
        $display("done after %0d cycles: %0d prediction mismatches, %0d property failures",
                 cycle_cnt, err_cnt, prop_errs);
        if (err_cnt == 0 && prop_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+verilog
verilog/npc_pkg.sv
verilog/btb.sv
verilog/ras.sv
verilog/target_chooser.sv
verilog/npc_predictor.sv
bench/clk_gen.sv
bench/npc_predictor_props.sv
bench/npc_predictor_tb.sv

// File: run.sh
#!/bin/sh
# build and run the next-address predictor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f src.f --top-module npc_predictor_tb -o npc_sim

out=$(./obj_dir/npc_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "SIMULATION PASSED"
